// File: hw/piano_pkg.sv
// Shared definitions for the note-memory piano game.
// The melody is fixed at build time and is also the number of rounds.
// Note codes are key indices 0 to NOTE_COUNT-1, so a code fits in three bits.
// TIMER_WIDTH must hold RESPONSE_CYCLES without overflow.

`default_nettype none

package piano_pkg;

    // ----------------------------------------------------------------------
    // Keyboard and melody
    // ----------------------------------------------------------------------
    localparam int NOTE_COUNT    = 7;
    localparam int MELODY_LENGTH = 8;

    typedef logic [2:0] note_t;
    typedef logic [2:0] note_index_t;
    typedef logic [3:0] round_t;

    // Stored tune, first note at index 0
    localparam note_t MELODY [MELODY_LENGTH] = '{
        3'd0,
        3'd2,
        3'd4,
        3'd2,
        3'd5,
        3'd6,
        3'd1,
        3'd3
    };

    // ----------------------------------------------------------------------
    // Timing, all in clock cycles
    // ----------------------------------------------------------------------
    localparam int SHOW_CYCLES     = 8;
    localparam int SHOW_GAP_CYCLES = 4;
    localparam int RESPONSE_CYCLES = 64;
    localparam int TIMER_WIDTH     = 7;

endpackage

`default_nettype wire

// File: hw/key_capture.sv
// Piano key capture.
// Keys are asynchronous and pass a two-stage synchronizer; no debounce is done.
// One strobe per release, only when exactly one key was held during the press.
// Chords and empty releases produce nothing.

`timescale 1ns/1ps
`default_nettype none

module key_capture
    import piano_pkg::*;
(
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic [NOTE_COUNT-1:0] keys,
    output logic                       note_valid,
    output note_t                      note_code
);

    logic [NOTE_COUNT-1:0] sync_0;
    logic [NOTE_COUNT-1:0] sync_1;
    logic                  active;
    logic                  chord;
    note_t                 held_code;

    // Index of the lowest key that is down
    function automatic note_t key_index(input logic [NOTE_COUNT-1:0] k);
        note_t idx;
        idx = '0;
        for (int i = NOTE_COUNT - 1; i >= 0; i--) begin
            if (k[i]) begin
                idx = note_t'(i);
            end
        end
        return idx;
    endfunction

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            sync_0 <= '0;
            sync_1 <= '0;
        end else begin
            sync_0 <= keys;
            sync_1 <= sync_0;
        end
    end

    // Press tracking and release edge
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            active     <= 1'b0;
            chord      <= 1'b0;
            held_code  <= '0;
            note_valid <= 1'b0;
        end else begin
            note_valid <= 1'b0;
            if (sync_1 != '0) begin
                active <= 1'b1;
                if (!$onehot(sync_1)) begin
                    chord <= 1'b1;
                end else if (active && held_code != key_index(sync_1)) begin
                    chord <= 1'b1;
                end else begin
                    held_code <= key_index(sync_1);
                end
            end else begin
                note_valid <= active && !chord;
                active     <= 1'b0;
                chord      <= 1'b0;
            end
        end
    end

    assign note_code = held_code;

    a_single_strobe: assert property (
        @(posedge clock) disable iff (reset) note_valid |=> !note_valid
    );

endmodule

`default_nettype wire

// File: hw/melody_rom.sv
// Melody store.
// Read is registered: read_note follows read_index by one cycle.
// Contents are fixed; there is no write port.

`timescale 1ns/1ps
`default_nettype none

module melody_rom
    import piano_pkg::*;
(
    input  wire logic         clock,
    input  wire logic         reset,
    input  wire note_index_t  read_index,
    output note_t             read_note
);

    always_ff @(posedge clock) begin
        read_note <= MELODY[read_index];
    end

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------
    a_index_range: assert property (
        @(posedge clock) disable iff (reset)
        !$isunknown(read_index) && int'(read_index) <= MELODY_LENGTH - 1
    );

endmodule

`default_nettype wire

// File: hw/interval_timer.sv
// Saturating cycle counter.
// Counts while enabled, holds at LENGTH, returns to zero on clear.
// LENGTH must fit in TIMER_WIDTH bits.

`timescale 1ns/1ps
`default_nettype none

module interval_timer
    import piano_pkg::*;
#(
    parameter int LENGTH = SHOW_CYCLES
) (
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic clear,
    input  wire logic enable,
    output logic      done,
    output logic      gap_done
);

    localparam logic [TIMER_WIDTH-1:0] LIMIT = TIMER_WIDTH'(LENGTH);
    localparam logic [TIMER_WIDTH-1:0] GAP   = TIMER_WIDTH'(SHOW_GAP_CYCLES);

    logic [TIMER_WIDTH-1:0] count;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (enable && count != LIMIT) begin
            count <= count + 1'b1;
        end
    end

    assign done     = (count == LIMIT);
    assign gap_done = (count == GAP);

    a_no_clear_enable: assert property (
        @(posedge clock) disable iff (reset) !(clear && enable)
    );

endmodule

`default_nettype wire

// File: hw/game_control.sv
// Game controller for the note-memory game.
// Round r shows the first r melody notes, then waits for the player to repeat them.
// A wrong note or a response timeout loses; finishing round MELODY_LENGTH wins.
// Note strobes outside await_note are dropped.
// won and lost hold until start.

`timescale 1ns/1ps
`default_nettype none

module game_control
    import piano_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  reset,
    input  wire logic  start,
    input  wire logic  note_valid,
    input  wire note_t note_code,
    output note_index_t read_index,
    input  wire note_t read_note,
    output logic        show_clear,
    output logic        show_enable,
    input  wire logic  show_done,
    input  wire logic  show_gap_done,
    output logic        response_clear,
    output logic        response_enable,
    input  wire logic  response_done,
    output note_t       show_note,
    output logic        show_valid,
    output logic        player_turn,
    output round_t      round,
    output logic        won,
    output logic        lost
);

    typedef enum logic [3:0] {
        IDLE,
        ROUND_START,
        FETCH,
        SHOW,
        GAP,
        AWAIT_NOTE,
        COMPARE,
        NEXT_NOTE,
        NEXT_ROUND,
        WON_STATE,
        LOST_STATE
    } state_t;

    state_t      state;
    state_t      state_next;
    note_index_t index;
    note_t       played;
    logic        last_index;

    assign last_index = (index == note_index_t'(round - 1'b1));

    // ----------------------------------------------------------------------
    // State register and counters
    // ----------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            index <= '0;
            round <= '0;
        end else begin
            state <= state_next;
            case (state)
                IDLE, WON_STATE, LOST_STATE: begin
                    if (start) begin
                        round <= round_t'(1);
                    end
                end
                ROUND_START, NEXT_ROUND: begin
                    index <= '0;
                    if (state == NEXT_ROUND) begin
                        round <= round + 1'b1;
                    end
                end
                // Last shown note hands the index back to 0 for the player
                GAP: begin
                    if (show_gap_done) begin
                        index <= last_index ? '0 : index + 1'b1;
                    end
                end
                NEXT_NOTE: index <= index + 1'b1;
                default: ;
            endcase
        end
    end

    // Played note, compared one cycle after capture
    always_ff @(posedge clock) begin
        if (state == AWAIT_NOTE && note_valid) begin
            played <= note_code;
        end
    end

    // ----------------------------------------------------------------------
    // Next state
    // ----------------------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            IDLE:        state_next = start ? ROUND_START : IDLE;
            ROUND_START: state_next = FETCH;
            FETCH:       state_next = SHOW;
            SHOW:        state_next = show_done ? GAP : SHOW;
            GAP: begin
                if (show_gap_done) begin
                    state_next = last_index ? AWAIT_NOTE : FETCH;
                end
            end
            AWAIT_NOTE: begin
                if (response_done) begin
                    state_next = LOST_STATE;
                end else if (note_valid) begin
                    state_next = COMPARE;
                end
            end
            COMPARE: begin
                if (played != read_note) begin
                    state_next = LOST_STATE;
                end else if (!last_index) begin
                    state_next = NEXT_NOTE;
                end else if (round == round_t'(MELODY_LENGTH)) begin
                    state_next = WON_STATE;
                end else begin
                    state_next = NEXT_ROUND;
                end
            end
            NEXT_NOTE:   state_next = AWAIT_NOTE;
            NEXT_ROUND:  state_next = FETCH;
            WON_STATE:   state_next = start ? ROUND_START : WON_STATE;
            LOST_STATE:  state_next = start ? ROUND_START : LOST_STATE;
            default:     state_next = IDLE;
        endcase
    end

    // ----------------------------------------------------------------------
    // Outputs
    // ----------------------------------------------------------------------
    assign read_index = index;
    assign show_note  = read_note;

    // Fetch pre-counts one cycle so show lasts exactly SHOW_CYCLES
    assign show_clear = (state == ROUND_START) || (state == NEXT_ROUND)
                     || (state == SHOW && show_done)
                     || (state == GAP && show_gap_done);
    assign show_enable = (state == FETCH)
                      || (state == SHOW && !show_done)
                      || (state == GAP && !show_gap_done);

    assign response_clear  = (state == GAP) || (state == NEXT_NOTE);
    assign response_enable = (state == AWAIT_NOTE);

    assign show_valid  = (state == SHOW);
    assign player_turn = (state == AWAIT_NOTE) || (state == COMPARE)
                      || (state == NEXT_NOTE);
    assign won  = (state == WON_STATE);
    assign lost = (state == LOST_STATE);

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------
    a_one_outcome: assert property (
        @(posedge clock) disable iff (reset) !(won && lost)
    );

    a_show_or_play: assert property (
        @(posedge clock) disable iff (reset) !(show_valid && player_turn)
    );

endmodule

`default_nettype wire

// File: hw/piano_game.sv
// Top level of the note-memory piano game.
// keys are raw and asynchronous; start is synchronous to clock.
// Outcome is reported on won and lost until the next start.

`timescale 1ns/1ps
`default_nettype none

module piano_game
    import piano_pkg::*;
(
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic                  start,
    input  wire logic [NOTE_COUNT-1:0] keys,
    output note_t                      show_note,
    output logic                       show_valid,
    output logic                       player_turn,
    output round_t                     round,
    output logic                       won,
    output logic                       lost
);

    logic        note_valid;
    note_t       note_code;
    note_index_t read_index;
    note_t       read_note;
    logic        show_clear;
    logic        show_enable;
    logic        show_done;
    logic        show_gap_done;
    logic        response_clear;
    logic        response_enable;
    logic        response_done;

    key_capture key_capture0 (
        .clock      (clock),
        .reset      (reset),
        .keys       (keys),
        .note_valid (note_valid),
        .note_code  (note_code)
    );

    melody_rom melody_rom0 (
        .clock      (clock),
        .reset      (reset),
        .read_index (read_index),
        .read_note  (read_note)
    );

    interval_timer #(.LENGTH(SHOW_CYCLES)) show_timer (
        .clock    (clock),
        .reset    (reset),
        .clear    (show_clear),
        .enable   (show_enable),
        .done     (show_done),
        .gap_done (show_gap_done)
    );

    // Gap flag of this instance is not needed by the controller
    interval_timer #(.LENGTH(RESPONSE_CYCLES)) response_timer (
        .clock    (clock),
        .reset    (reset),
        .clear    (response_clear),
        .enable   (response_enable),
        .done     (response_done),
        .gap_done ()
    );

    game_control game_control0 (
        .clock           (clock),
        .reset           (reset),
        .start           (start),
        .note_valid      (note_valid),
        .note_code       (note_code),
        .read_index      (read_index),
        .read_note       (read_note),
        .show_clear      (show_clear),
        .show_enable     (show_enable),
        .show_done       (show_done),
        .show_gap_done   (show_gap_done),
        .response_clear  (response_clear),
        .response_enable (response_enable),
        .response_done   (response_done),
        .show_note       (show_note),
        .show_valid      (show_valid),
        .player_turn     (player_turn),
        .round           (round),
        .won             (won),
        .lost            (lost)
    );

endmodule

`default_nettype wire

// File: verification/piano_model.svh
// Reference model of the note-memory game.
// Tracks round, note position and outcome from the keys the player plays.
// Included inside the testbench module, which imports piano_pkg.

`ifndef PIANO_MODEL_SVH
`define PIANO_MODEL_SVH

int model_round;
int model_index;
bit model_won;
bit model_lost;

function automatic void model_start();
    model_round = 1;
    model_index = 0;
    model_won   = 1'b0;
    model_lost  = 1'b0;
endfunction

// n-th note of every showing
function automatic note_t model_shown(input int n);
    return MELODY[n];
endfunction

function automatic note_t model_expected();
    return MELODY[model_index];
endfunction

// One key accepted by the game while waiting for a note
function automatic void model_play(input note_t key);
    if (key != MELODY[model_index]) begin
        model_lost = 1'b1;
    end else if (model_index == model_round - 1) begin
        if (model_round == MELODY_LENGTH) begin
            model_won = 1'b1;
        end else begin
            model_round++;
            model_index = 0;
        end
    end else begin
        model_index++;
    end
endfunction

function automatic void model_timeout();
    model_lost = 1'b1;
endfunction

`endif

// File: verification/piano_game_tb.sv
// Testbench for the note-memory piano game.
// Plays several games with random player behavior from a fixed seed.
// Shown notes and outcomes are checked against the model in piano_model.svh.

`timescale 1ns/1ps
`default_nettype none

module piano_game_tb
    import piano_pkg::*;
();

    logic                  clock;
    logic                  reset;
    logic                  start;
    logic [NOTE_COUNT-1:0] keys;
    note_t                 show_note;
    logic                  show_valid;
    logic                  player_turn;
    round_t                round;
    logic                  won;
    logic                  lost;
    integer                seed;

    `include "piano_model.svh"

    piano_game dut0 (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .keys        (keys),
        .show_note   (show_note),
        .show_valid  (show_valid),
        .player_turn (player_turn),
        .round       (round),
        .won         (won),
        .lost        (lost)
    );

    always #2 clock = ~clock;

    // ----------------------------------------------------------------------
    // Checks and helpers
    // ----------------------------------------------------------------------
    task automatic check_equal(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        $display("test failed");
        $fatal(1, "timeout");
    endtask

    function automatic int random_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [NOTE_COUNT-1:0] key_mask(input int k);
        logic [NOTE_COUNT-1:0] mask;
        mask    = '0;
        mask[k] = 1'b1;
        return mask;
    endfunction

    task automatic check_quiet(input int turn);
        check_equal(player_turn, turn, "player_turn");
        check_equal(show_valid, 0, "show_valid");
        check_equal(won, model_won, "won");
        check_equal(lost, model_lost, "lost");
    endtask

    // Hold keys for 1 to 5 cycles, return at the release edge
    task automatic hold_keys(input logic [NOTE_COUNT-1:0] mask);
        int hold;
        hold = 1 + random_below(5);
        keys = mask;
        repeat (hold) @(negedge clock);
        keys = '0;
    endtask

    task automatic settle();
        repeat (6) @(negedge clock);
        check_quiet(1);
    endtask

    // Count and check shown notes until player_turn rises
    task automatic watch_showing();
        int   shown;
        int   high_len;
        int   cycles;
        logic prev_show;
        logic prev_turn;
        shown     = 0;
        high_len  = 0;
        cycles    = 0;
        prev_show = 1'b0;
        do begin
            prev_turn = player_turn;
            @(negedge clock);
            cycles++;
            if (cycles > 600) begin
                abort_on_timeout("player_turn never rose after the showing");
            end
            if (show_valid && prev_show) begin
                check_equal(show_note, model_shown(shown - 1), "steady shown note");
            end
            if (show_valid && !prev_show) begin
                check_equal(shown < model_round, 1, "no extra shown note");
                check_equal(show_note, model_shown(shown), "shown note");
                shown++;
                high_len = 0;
            end
            if (!show_valid && prev_show) begin
                check_equal(high_len, SHOW_CYCLES, "show_valid high cycles");
            end
            high_len += int'(show_valid);
            check_equal(won || lost, 0, "outcome during showing");
            prev_show = show_valid;
        end while (!(player_turn && !prev_turn));
        check_equal(shown, model_round, "notes shown before player_turn");
        check_equal(round, model_round, "round");
    endtask

    task automatic wait_outcome(input int limit, output int cycles);
        cycles = 0;
        while (!won && !lost) begin
            @(negedge clock);
            cycles++;
            if (cycles > limit) begin
                abort_on_timeout("neither won nor lost rose");
            end
        end
        check_equal(won, model_won, "won");
        check_equal(lost, model_lost, "lost");
    endtask

    // Outcome must hold, a stray key included
    task automatic hold_outcome();
        int i;
        for (i = 0; i < 40; i++) begin
            keys = (i >= 4 && i < 8) ? key_mask(2) : '0;
            @(negedge clock);
            check_quiet(0);
        end
    endtask

    // ----------------------------------------------------------------------
    // One game; error_rate is the percent chance of a mistake per note
    // ----------------------------------------------------------------------
    task automatic play_game(input int error_rate);
        int    pick;
        int    waited;
        int    last_round;
        int    other;
        note_t key;
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        model_start();
        watch_showing();
        while (!model_won && !model_lost) begin
            pick       = random_below(100);
            key        = model_expected();
            last_round = model_round;
            if (pick < error_rate / 2) begin
                // Idle past the response limit
                model_timeout();
                wait_outcome(2 * RESPONSE_CYCLES, waited);
                check_equal(waited >= RESPONSE_CYCLES - 8, 1, "lost after the response limit");
            end else begin
                if (pick < error_rate) begin
                    key = note_t'((key + 1 + random_below(NOTE_COUNT - 1)) % NOTE_COUNT);
                end else if (pick < error_rate + 12) begin
                    other = (key + 1 + random_below(NOTE_COUNT - 1)) % NOTE_COUNT;
                    hold_keys(key_mask(key) | key_mask(other));
                    settle();
                end
                hold_keys(key_mask(key));
                model_play(key);
                if (model_won || model_lost) begin
                    wait_outcome(16, waited);
                end else if (model_round != last_round) begin
                    watch_showing();
                end else begin
                    settle();
                end
            end
        end
        hold_outcome();
    endtask

    initial begin
        int game;
        seed  = 49;
        clock = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        keys  = '0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        repeat (20) begin
            @(negedge clock);
            check_quiet(0);
            check_equal(round, 0, "round before start");
        end
        play_game(0);
        for (game = 0; game < 4; game++) begin
            play_game(8);
        end
        play_game(0);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+verification
hw/piano_pkg.sv
hw/key_capture.sv
hw/melody_rom.sv
hw/interval_timer.sv
hw/game_control.sv
hw/piano_game.sv
verification/piano_game_tb.sv
